// ==== sysbus_pkg.sv ====
package sysbus_pkg;

    localparam int BUS_DATA_WIDTH = 64;
    localparam int BUS_TAG_WIDTH = 13;

    localparam int LINE_BEATS = 8;
    localparam int LINE_WIDTH = BUS_DATA_WIDTH * LINE_BEATS;
    localparam int LINE_OFFSET_BITS = 6;
    localparam int BEAT_BITS = $clog2(LINE_BEATS);
    localparam int WORD_OFFSET_BITS = $clog2(BUS_DATA_WIDTH / 8);

    localparam int MEM_LINES = 64;
    localparam int MEM_WORDS = MEM_LINES * LINE_BEATS;
    localparam int LINE_INDEX_BITS = $clog2(MEM_LINES);
    localparam int MEM_INDEX_BITS = $clog2(MEM_WORDS);

    localparam int MEM_LATENCY = 4;
    localparam int LAT_CNT_BITS = $clog2(MEM_LATENCY);
    // Request cycle and the capture edge eat two of the latency cycles.
    localparam logic [LAT_CNT_BITS-1:0] LAT_LOAD = LAT_CNT_BITS'(MEM_LATENCY - 2);

    typedef enum logic {
        SYSBUS_WRITE = 1'b0,
        SYSBUS_READ  = 1'b1
    } sysbus_op_e;             // Tag bit 12.

    typedef enum logic [3:0] {
        SYSBUS_MEMORY = 4'b0001,
        SYSBUS_MMIO   = 4'b0011
    } sysbus_dev_e;            // Tag bits 11 to 8.

    localparam logic [BUS_TAG_WIDTH-1:0] READ_MEM_TAG = {SYSBUS_READ, SYSBUS_MEMORY, 8'h00};

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_ARB,
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_RESP,
        FETCH_READY
    } fetch_state_e;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_LAT,
        MEM_STREAM
    } mem_state_e;

endpackage

// ==== sysbus_if.sv ====
`timescale 1ns/1ps

interface sysbus_if;

    // Request side, one cycle strobe.
    logic                                  reqcyc;
    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] req;     // Line address.
    logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  reqtag;

    // Response beats, held until acknowledged.
    logic                                  respcyc;
    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] resp;
    logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  resptag;
    logic                                  respack;

    modport master
    (
        output reqcyc,
        output req,
        output reqtag,
        output respack,
        input  respcyc,
        input  resp,
        input  resptag
    );

    modport slave
    (
        input  reqcyc,
        input  req,
        input  reqtag,
        input  respack,
        output respcyc,
        output resp,
        output resptag
    );

endinterface

// ==== line_fetcher.sv ====
`timescale 1ns/1ps

module line_fetcher
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  enable,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] addr,
    output logic                                  ready,
    output logic [sysbus_pkg::LINE_WIDTH-1:0]     line,
    output logic                                  arb_req,
    input  logic                                  arb_grant,
    sysbus_if.master                              bus
);

    sysbus_pkg::fetch_state_e state;
    sysbus_pkg::fetch_state_e state_next;

    logic [3:0]                            beat_cnt;
    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] line_addr;
    logic                                  client_idle;
    logic                                  beat_ok;
    logic                                  last_beat;

    // Client inputs only count while nothing is in flight.
    assign client_idle = (state == sysbus_pkg::FETCH_IDLE) ||
                         (state == sysbus_pkg::FETCH_READY);

    // Foreign tags are acked by respack but never stored.
    assign beat_ok = (state == sysbus_pkg::FETCH_RESP) && bus.respcyc &&
                     (bus.resptag == sysbus_pkg::READ_MEM_TAG);

    assign last_beat = (beat_cnt == sysbus_pkg::LINE_BEATS - 1);

    always_comb
    begin
        state_next = state;
        case (state)
            sysbus_pkg::FETCH_IDLE,
            sysbus_pkg::FETCH_READY:
            begin
                if (enable)
                    state_next = sysbus_pkg::FETCH_ARB;
            end
            sysbus_pkg::FETCH_ARB:
            begin
                if (arb_grant)
                    state_next = sysbus_pkg::FETCH_REQ;
            end
            sysbus_pkg::FETCH_REQ:
            begin
                state_next = sysbus_pkg::FETCH_WAIT;
            end
            sysbus_pkg::FETCH_WAIT:
            begin
                if (bus.respcyc)
                    state_next = sysbus_pkg::FETCH_RESP;
            end
            sysbus_pkg::FETCH_RESP:
            begin
                if (beat_ok && last_beat)
                    state_next = sysbus_pkg::FETCH_READY;
            end
            default:
            begin
                state_next = sysbus_pkg::FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= sysbus_pkg::FETCH_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            beat_cnt <= '0;
        else if (state == sysbus_pkg::FETCH_REQ)
            beat_cnt <= '0;
        else if (beat_ok)
            beat_cnt <= beat_cnt + 4'd1;
    end

    always_ff @(posedge clk)
    begin
        if (client_idle && enable)
            line_addr <= {addr[sysbus_pkg::BUS_DATA_WIDTH-1:sysbus_pkg::LINE_OFFSET_BITS],
                          {sysbus_pkg::LINE_OFFSET_BITS{1'b0}}};
        if (beat_ok)
            line[beat_cnt[sysbus_pkg::BEAT_BITS-1:0] * sysbus_pkg::BUS_DATA_WIDTH +:
                 sysbus_pkg::BUS_DATA_WIDTH] <= bus.resp;   // Lowest word arrives first.
    end

    // Bus request is dropped as soon as the line is complete.
    assign arb_req = (state == sysbus_pkg::FETCH_ARB)  ||
                     (state == sysbus_pkg::FETCH_REQ)  ||
                     (state == sysbus_pkg::FETCH_WAIT) ||
                     (state == sysbus_pkg::FETCH_RESP);

    assign bus.reqcyc  = (state == sysbus_pkg::FETCH_REQ);
    assign bus.req     = line_addr;
    assign bus.reqtag  = sysbus_pkg::READ_MEM_TAG;
    assign bus.respack = (state == sysbus_pkg::FETCH_RESP);

    assign ready = (state == sysbus_pkg::FETCH_READY);

endmodule

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req_i,
    input  logic     req_d,
    output logic     grant_i,
    output logic     grant_d,
    sysbus_if.slave  ifetch,
    sysbus_if.slave  dfetch,
    sysbus_if.master mem
);

    logic next_i;
    logic next_d;
    logic last_d;      // High when dfetch held the bus last.

    always_comb
    begin
        next_i = grant_i && req_i;     // Owner keeps the bus until it lets go.
        next_d = grant_d && req_d;
        if (!next_i && !next_d)
        begin
            if (req_i && req_d)
            begin
                next_i = last_d;
                next_d = !last_d;
            end
            else
            begin
                next_i = req_i;
                next_d = req_d;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grant_i <= 1'b0;
            grant_d <= 1'b0;
            last_d  <= 1'b0;
        end
        else
        begin
            grant_i <= next_i;
            grant_d <= next_d;
            if (next_i)
                last_d <= 1'b0;
            else if (next_d)
                last_d <= 1'b1;
        end
    end

    always_comb
    begin
        mem.reqcyc  = 1'b0;
        mem.req     = '0;
        mem.reqtag  = '0;
        mem.respack = 1'b0;

        // Data fans out to both, only the owner sees respcyc.
        ifetch.resp    = mem.resp;
        ifetch.resptag = mem.resptag;
        ifetch.respcyc = 1'b0;
        dfetch.resp    = mem.resp;
        dfetch.resptag = mem.resptag;
        dfetch.respcyc = 1'b0;

        if (grant_i)
        begin
            mem.reqcyc     = ifetch.reqcyc;
            mem.req        = ifetch.req;
            mem.reqtag     = ifetch.reqtag;
            mem.respack    = ifetch.respack;
            ifetch.respcyc = mem.respcyc;
        end
        else if (grant_d)
        begin
            mem.reqcyc     = dfetch.reqcyc;
            mem.req        = dfetch.req;
            mem.reqtag     = dfetch.reqtag;
            mem.respack    = dfetch.respack;
            dfetch.respcyc = mem.respcyc;
        end
    end

endmodule

// ==== line_memory.sv ====
`timescale 1ns/1ps

module line_memory
(
    input  logic                                  clk,
    input  logic                                  reset,
    sysbus_if.slave                               bus,
    input  logic                                  load_en,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] load_addr,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] load_data
);

    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] mem [sysbus_pkg::MEM_WORDS];

    sysbus_pkg::mem_state_e state;

    logic [sysbus_pkg::LINE_INDEX_BITS-1:0] line_idx;
    logic [sysbus_pkg::BEAT_BITS-1:0]       beat;
    logic [sysbus_pkg::LAT_CNT_BITS-1:0]    lat_cnt;
    logic [sysbus_pkg::MEM_INDEX_BITS-1:0]  load_idx;
    logic                                   req_hit;

    // Only memory reads are answered.
    assign req_hit = bus.reqcyc && (bus.reqtag == sysbus_pkg::READ_MEM_TAG);

    // Word index, upper address bits wrap around the array.
    assign load_idx = load_addr[sysbus_pkg::WORD_OFFSET_BITS +: sysbus_pkg::MEM_INDEX_BITS];

    always_ff @(posedge clk)
    begin
        if (load_en)
            mem[load_idx] <= load_data;
    end

    always_ff @(posedge clk)
    begin
        if (state == sysbus_pkg::MEM_IDLE && req_hit)
            line_idx <= bus.req[sysbus_pkg::LINE_OFFSET_BITS +: sysbus_pkg::LINE_INDEX_BITS];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= sysbus_pkg::MEM_IDLE;
            beat    <= '0;
            lat_cnt <= '0;
        end
        else
        begin
            case (state)
                sysbus_pkg::MEM_IDLE:
                begin
                    if (req_hit)
                    begin
                        state   <= sysbus_pkg::MEM_LAT;
                        lat_cnt <= sysbus_pkg::LAT_LOAD;
                        beat    <= '0;
                    end
                end
                sysbus_pkg::MEM_LAT:
                begin
                    if (lat_cnt == '0)
                        state <= sysbus_pkg::MEM_STREAM;
                    else
                        lat_cnt <= lat_cnt - 1'b1;
                end
                sysbus_pkg::MEM_STREAM:
                begin
                    if (bus.respack)
                    begin
                        beat <= beat + 1'b1;    // Beat held until acked.
                        if (beat == sysbus_pkg::LINE_BEATS - 1)
                            state <= sysbus_pkg::MEM_IDLE;
                    end
                end
                default:
                begin
                    state <= sysbus_pkg::MEM_IDLE;
                end
            endcase
        end
    end

    assign bus.respcyc = (state == sysbus_pkg::MEM_STREAM);
    assign bus.resp    = mem[{line_idx, beat}];
    assign bus.resptag = sysbus_pkg::READ_MEM_TAG;

endmodule

// ==== fetch_subsystem.sv ====
`timescale 1ns/1ps

module fetch_subsystem
(
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  ifetch_enable,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] ifetch_addr,
    output logic                                  ifetch_ready,
    output logic [sysbus_pkg::LINE_WIDTH-1:0]     ifetch_line,

    input  logic                                  dfetch_enable,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] dfetch_addr,
    output logic                                  dfetch_ready,
    output logic [sysbus_pkg::LINE_WIDTH-1:0]     dfetch_line,

    input  logic                                  load_en,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] load_addr,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] load_data
);

    logic ifetch_arb_req;
    logic ifetch_arb_grant;
    logic dfetch_arb_req;
    logic dfetch_arb_grant;

    sysbus_if ifetch_bus ();
    sysbus_if dfetch_bus ();
    sysbus_if mem_bus ();      // Arbiter to memory.

    line_fetcher ifetch
    (
        .clk       (clk),
        .reset     (reset),
        .enable    (ifetch_enable),
        .addr      (ifetch_addr),
        .ready     (ifetch_ready),
        .line      (ifetch_line),
        .arb_req   (ifetch_arb_req),
        .arb_grant (ifetch_arb_grant),
        .bus       (ifetch_bus.master)
    );

    line_fetcher dfetch
    (
        .clk       (clk),
        .reset     (reset),
        .enable    (dfetch_enable),
        .addr      (dfetch_addr),
        .ready     (dfetch_ready),
        .line      (dfetch_line),
        .arb_req   (dfetch_arb_req),
        .arb_grant (dfetch_arb_grant),
        .bus       (dfetch_bus.master)
    );

    bus_arbiter arbiter
    (
        .clk     (clk),
        .reset   (reset),
        .req_i   (ifetch_arb_req),
        .req_d   (dfetch_arb_req),
        .grant_i (ifetch_arb_grant),
        .grant_d (dfetch_arb_grant),
        .ifetch  (ifetch_bus.slave),
        .dfetch  (dfetch_bus.slave),
        .mem     (mem_bus.master)
    );

    line_memory memory
    (
        .clk       (clk),
        .reset     (reset),
        .bus       (mem_bus.slave),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// ==== tb_fetch_subsystem.sv ====
`timescale 1ns/1ps

module tb_fetch_subsystem;

    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CHECKS = 4;
    localparam int SEQUENCES = 30;
    localparam int FETCH_COUNT = 4 + 2 * SEQUENCES;    // Singles, one pair, then the sequences.
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CHECKS + sysbus_pkg::MEM_WORDS +
                                    40 * FETCH_COUNT;
    localparam int INDEX_SHIFT = sysbus_pkg::MEM_INDEX_BITS + sysbus_pkg::WORD_OFFSET_BITS;

    logic                                  clk;
    logic                                  reset;
    logic                                  ifetch_enable;
    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] ifetch_addr;
    logic                                  ifetch_ready;
    logic [sysbus_pkg::LINE_WIDTH-1:0]     ifetch_line;
    logic                                  dfetch_enable;
    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] dfetch_addr;
    logic                                  dfetch_ready;
    logic [sysbus_pkg::LINE_WIDTH-1:0]     dfetch_line;
    logic                                  load_en;
    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] load_addr;
    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] load_data;

    logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] model_mem [sysbus_pkg::MEM_WORDS];
    logic [sysbus_pkg::LINE_WIDTH-1:0]     last_line [2];
    logic                                  last_valid [2];
    logic [15:0]                           lfsr;
    int                                    errors;
    int                                    cycles;

    fetch_subsystem dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, ready never arrived", cycles);
            errors = errors + 1;
            $display("Errors: %0d", errors);
            $display("sim failed");
            $finish;
        end
    end

    // Fibonacci LFSR on taps 16, 14, 13 and 11 that steps once per bit.
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_equal(input string name, input logic [sysbus_pkg::LINE_WIDTH-1:0] actual,
                               input logic [sysbus_pkg::LINE_WIDTH-1:0] expected);
        if (actual !== expected)
        begin
            $display("** Error %s: got %0h, expected %0h", name, actual, expected);
            errors = errors + 1;
        end
    endtask

    function automatic logic port_ready(input int port);
        return port ? dfetch_ready : ifetch_ready;
    endfunction

    function automatic logic [sysbus_pkg::LINE_WIDTH-1:0] port_line(input int port);
        return port ? dfetch_line : ifetch_line;
    endfunction

    task automatic set_client(input int port, input logic en, input logic [63:0] a);
        if (port)
        begin
            dfetch_enable = en;
            dfetch_addr   = a;
        end
        else
        begin
            ifetch_enable = en;
            ifetch_addr   = a;
        end
    endtask

    // Line index wraps at the memory size.
    function automatic logic [sysbus_pkg::LINE_WIDTH-1:0] model_line(input logic [63:0] a);
        logic [sysbus_pkg::LINE_WIDTH-1:0] l;
        int                                base;
        int                                b;
        base = int'((a >> sysbus_pkg::LINE_OFFSET_BITS) % sysbus_pkg::MEM_LINES);
        for (b = 0; b < sysbus_pkg::LINE_BEATS; b++)
            l[b * 64 +: 64] = model_mem[base * sysbus_pkg::LINE_BEATS + b];
        return l;
    endfunction

    task automatic preload_memory();
        logic [63:0] a;
        int          i;
        int          idx;
        for (i = 0; i < sysbus_pkg::MEM_WORDS; i++)
        begin
            a = random_bits(sysbus_pkg::BUS_DATA_WIDTH - INDEX_SHIFT) << INDEX_SHIFT;
            a = a | (64'(i) << sysbus_pkg::WORD_OFFSET_BITS);   // Random upper bits wrap.
            idx = int'((a >> sysbus_pkg::WORD_OFFSET_BITS) % sysbus_pkg::MEM_WORDS);
            load_en   = 1'b1;
            load_addr = a;
            load_data = random_bits(64);
            model_mem[idx] = load_data;
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    // One fetch with an optional enable poked in while the fetcher is busy.
    task automatic run_fetch(input int port, input logic [63:0] fetch_addr,
                             input logic [63:0] poke_addr, input int poke_delay);
        logic [sysbus_pkg::LINE_WIDTH-1:0] expected;
        string                             name;
        int                                waited;
        expected = model_line(fetch_addr);
        name = port ? "dfetch" : "ifetch";
        if (last_valid[port])
        begin
            check_equal({name, "_ready"}, port_ready(port), 1'b1);
            check_equal({name, "_line"}, port_line(port), last_line[port]);
        end
        set_client(port, 1'b1, fetch_addr);
        @(negedge clk);
        set_client(port, 1'b0, fetch_addr);
        check_equal({name, "_ready"}, port_ready(port), 1'b0);
        waited = 0;
        while (poke_delay >= 0 && waited < poke_delay && !port_ready(port))
        begin
            @(negedge clk);
            waited++;
        end
        if (poke_delay >= 0 && !port_ready(port))
        begin
            set_client(port, 1'b1, poke_addr);
            @(negedge clk);
            set_client(port, 1'b0, fetch_addr);
        end
        while (!port_ready(port))
            @(negedge clk);
        check_equal({name, "_line"}, port_line(port), expected);
        repeat (2)
        begin
            @(negedge clk);
            check_equal({name, "_ready"}, port_ready(port), 1'b1);
            check_equal({name, "_line"}, port_line(port), expected);
        end
        last_line[port]  = expected;
        last_valid[port] = 1'b1;
    endtask

    initial
    begin
        logic [63:0] addr_i;
        logic [63:0] addr_d;
        logic [63:0] alt_i;
        logic [63:0] alt_d;
        logic [1:0]  mode;
        int          delay_i;
        int          delay_d;
        int          poke_i;
        int          poke_d;
        int          seq;
        errors = 0;
        cycles = 0;
        lfsr = 16'd52;
        last_valid[0] = 1'b0;
        last_valid[1] = 1'b0;
        reset = 1'b1;
        ifetch_enable = 1'b0;
        ifetch_addr = '0;
        dfetch_enable = 1'b0;
        dfetch_addr = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        repeat (IDLE_CHECKS)
        begin
            @(negedge clk);
            check_equal("ifetch_ready", ifetch_ready, 1'b0);
            check_equal("dfetch_ready", dfetch_ready, 1'b0);
        end
        preload_memory();
        run_fetch(0, random_bits(12), '0, -1);
        run_fetch(1, random_bits(12), '0, -1);
        addr_i = random_bits(12);
        addr_d = random_bits(12);
        fork
            run_fetch(0, addr_i, '0, -1);
            run_fetch(1, addr_d, '0, -1);
        join
        for (seq = 0; seq < SEQUENCES; seq++)
        begin
            mode    = 2'(random_bits(2));        // 0 ifetch only, 1 dfetch only, else both.
            addr_i  = random_bits(64);
            addr_d  = random_bits(64);
            alt_i   = random_bits(64);
            alt_d   = random_bits(64);
            delay_i = int'(random_bits(2));
            delay_d = int'(random_bits(2));
            poke_i  = random_bits(1) ? int'(random_bits(3)) : -1;
            poke_d  = random_bits(1) ? int'(random_bits(3)) : -1;
            fork
                if (mode != 2'd1)
                begin
                    repeat (delay_i) @(negedge clk);
                    run_fetch(0, addr_i, alt_i, poke_i);
                end
                if (mode != 2'd0)
                begin
                    repeat (delay_d) @(negedge clk);
                    run_fetch(1, addr_d, alt_d, poke_d);
                end
            join
        end
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
sysbus_pkg.sv
sysbus_if.sv
line_fetcher.sv
bus_arbiter.sv
line_memory.sv
fetch_subsystem.sv
tb_fetch_subsystem.sv
